// ==== all.f ====
+incdir+logic
+incdir+bench
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/control_decoder.sv
logic/imm_gen.sv
logic/register_file.sv
logic/decode_stage.sv
bench/decode_tb.sv

// ==== bench/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected decode results, taken from the RV32I encoding tables

function automatic ctrl_pkg::alu_op_t ref_alu_op(input logic [31:0] ir);
  logic [6:0] op;
  logic [2:0] f3;
  logic       alt;  // funct7 bit 5
  op  = ir[6:0];
  f3  = ir[14:12];
  alt = ir[30];
  if (op == isa_pkg::OP_BRANCH) begin
    case (f3)
      3'b000, 3'b001: return ctrl_pkg::ALU_SUB;
      3'b100, 3'b101: return ctrl_pkg::ALU_LESS_THAN_SIGNED;
      3'b110, 3'b111: return ctrl_pkg::ALU_LESS_THAN_UNSIGNED;
      default: return ctrl_pkg::ALU_ADD;
    endcase
  end
  if (op != isa_pkg::OP_REG && op != isa_pkg::OP_IMM) begin
    return ctrl_pkg::ALU_ADD;
  end
  case (f3)
    3'b000: return (alt && op == isa_pkg::OP_REG) ? ctrl_pkg::ALU_SUB : ctrl_pkg::ALU_ADD;
    3'b001: return ctrl_pkg::ALU_SHIFT_LEFT;
    3'b010: return ctrl_pkg::ALU_LESS_THAN_SIGNED;
    3'b011: return ctrl_pkg::ALU_LESS_THAN_UNSIGNED;
    3'b100: return ctrl_pkg::ALU_XOR;
    3'b101: return alt ? ctrl_pkg::ALU_SHIFT_RIGHT_AR : ctrl_pkg::ALU_SHIFT_RIGHT;
    3'b110: return ctrl_pkg::ALU_OR;
    default: return ctrl_pkg::ALU_AND;
  endcase
endfunction

function automatic ctrl_pkg::control_t ref_control(input logic [31:0] ir);
  ctrl_pkg::control_t c;
  c = '0;
  c.encoding = isa_pkg::R_TYPE;
  c.alu_op   = ref_alu_op(ir);
  case (ir[6:0])
    isa_pkg::OP_REG: c.reg_write = 1'b1;
    isa_pkg::OP_IMM, isa_pkg::OP_JALR: begin
      c.encoding  = isa_pkg::I_TYPE;
      c.alu_src   = 1'b1;
      c.reg_write = 1'b1;
    end
    isa_pkg::OP_LOAD: begin
      c.encoding   = isa_pkg::I_TYPE;
      c.alu_src    = 1'b1;
      c.reg_write  = 1'b1;
      c.mem_read   = 1'b1;
      c.mem_to_reg = 1'b1;
    end
    isa_pkg::OP_STORE: begin
      c.encoding  = isa_pkg::S_TYPE;
      c.alu_src   = 1'b1;
      c.mem_write = 1'b1;
    end
    isa_pkg::OP_BRANCH: begin
      c.encoding  = isa_pkg::B_TYPE;
      c.is_branch = 1'b1;
    end
    isa_pkg::OP_LUI, isa_pkg::OP_AUIPC: begin
      c.encoding  = isa_pkg::U_TYPE;
      c.alu_src   = 1'b1;
      c.reg_write = 1'b1;
    end
    isa_pkg::OP_JAL: begin
      c.encoding  = isa_pkg::J_TYPE;
      c.alu_src   = 1'b1;
      c.reg_write = 1'b1;
    end
    default: c.alu_op = ctrl_pkg::ALU_ADD;  // inert word for unknown opcodes
  endcase
  if (c.reg_write) begin
    c.write_back_id = ir[11:7];
  end
  return c;
endfunction

// treats the low width bits of raw as a two's complement number
function automatic logic [31:0] sign_extend(input logic [31:0] raw, input int width);
  logic signed [31:0] t;
  t = raw << (32 - width);
  return t >>> (32 - width);
endfunction

function automatic logic [31:0] ref_immediate(input logic [31:0] ir);
  ctrl_pkg::control_t c;
  c = ref_control(ir);
  case (c.encoding)
    isa_pkg::I_TYPE: return sign_extend({20'b0, ir[31:20]}, 12);
    isa_pkg::S_TYPE: return sign_extend({20'b0, ir[31:25], ir[11:7]}, 12);
    isa_pkg::B_TYPE: return sign_extend({19'b0, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0}, 13);
    isa_pkg::U_TYPE: return {ir[31:12], 12'b0};
    isa_pkg::J_TYPE: return sign_extend({11'b0, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0}, 21);
    default: return '0;
  endcase
endfunction

`endif

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module decode_tb;

  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 4;
  localparam int N_WRITES       = 48;
  localparam int N_X0_WRITES    = 8;
  localparam int N_BYPASS       = 16;
  localparam int N_OPCODES      = 9;
  localparam int N_RANDOM_WORDS = 64;
  localparam int N_IMM_PER_OP   = 8;
  localparam int TEST_CYCLES    = RESET_CYCLES + 1 + `NREGS + N_WRITES + `NREGS
                                + N_X0_WRITES + 1 + 2 * N_BYPASS + N_OPCODES * 16
                                + N_RANDOM_WORDS + N_OPCODES * N_IMM_PER_OP + 2;
  localparam int WATCHDOG_NS    = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  isa_pkg::instruction_t instruction;
  logic                  reg_write;
  isa_pkg::reg_idx_t     write_id;
  isa_pkg::word_t        write_data;
  ctrl_pkg::control_t    control;
  isa_pkg::word_t        immediate_data;
  isa_pkg::reg_idx_t     rs1;
  isa_pkg::reg_idx_t     rs2;
  isa_pkg::word_t        read1_data;
  isa_pkg::word_t        read2_data;

  isa_pkg::word_t   shadow [`NREGS];  // register contents as the bench expects them
  isa_pkg::opcode_t opcode_list [N_OPCODES];
  integer           seed = 32'h0abb04c6;
  int               checks = 0;
  int               errors = 0;

  `include "decode_ref.svh"

  decode_stage dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instruction    (instruction),
    .reg_write      (reg_write),
    .write_id       (write_id),
    .write_data     (write_data),
    .control        (control),
    .immediate_data (immediate_data),
    .rs1            (rs1),
    .rs2            (rs2),
    .read1_data     (read1_data),
    .read2_data     (read2_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  function automatic logic [4:0] random_nonzero_index();
    logic [31:0] r;
    r = $unsigned($random(seed)) % 31 + 1;
    return r[4:0];
  endfunction

  function automatic logic [31:0] with_sources(input logic [31:0] base, input logic [4:0] a,
                                               input logic [4:0] b);
    logic [31:0] w;
    w = base;
    w[19:15] = a;
    w[24:20] = b;
    return w;
  endfunction

  // a read port shows a same cycle write in place of the stored word
  function automatic logic [31:0] expected_read(input logic [4:0] idx);
    if (idx == '0) begin
      return '0;
    end
    if (reg_write && write_id == idx) begin
      return write_data;
    end
    return shadow[idx];
  endfunction

  task automatic drive_cycle(input logic [31:0] instr, input logic we, input logic [4:0] wid,
                             input logic [31:0] wdata);
    @(posedge clk);
    #1;
    instruction = instr;
    reg_write   = we;
    write_id    = wid;
    write_data  = wdata;
  endtask

  // random instruction bits together with a random write port
  task automatic drive_with_noise(input logic [31:0] instr);
    logic [31:0] r;
    r = random_word();
    drive_cycle(instr, r[0], r[9:5], random_word());
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h at %0t ns", name, expected, actual,
               $time);
      errors++;
    end
  endtask

  // samples the outputs 1 ns before the rising edge when everything has settled
  initial begin : compare
    logic [31:0] ir;
    forever begin
      @(posedge clk);
      #(CLK_PERIOD - 1);
      if (!rst_n) begin
        for (int i = 0; i < `NREGS; i++) begin
          shadow[i] = '0;
        end
      end else begin
        ir = instruction;
        check_word("control", 32'(ref_control(ir)), 32'(control));
        check_word("immediate_data", ref_immediate(ir), immediate_data);
        check_word("rs1", 32'(ir[19:15]), 32'(rs1));
        check_word("rs2", 32'(ir[24:20]), 32'(rs2));
        check_word("read1_data", expected_read(ir[19:15]), read1_data);
        check_word("read2_data", expected_read(ir[24:20]), read2_data);
        if (reg_write && write_id != '0) begin
          shadow[write_id] = write_data;  // lands at the coming edge
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] instr;
    logic [4:0]  idx;
    instruction = '0;
    reg_write   = 1'b0;
    write_id    = '0;
    write_data  = '0;
    rst_n       = 1'b0;
    opcode_list = '{isa_pkg::OP_LUI, isa_pkg::OP_AUIPC, isa_pkg::OP_JAL, isa_pkg::OP_JALR,
                    isa_pkg::OP_BRANCH, isa_pkg::OP_LOAD, isa_pkg::OP_STORE, isa_pkg::OP_IMM,
                    isa_pkg::OP_REG};
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // every index reads zero after reset
    for (int i = 0; i < `NREGS; i++) begin
      drive_cycle(with_sources(random_word(), 5'(i), 5'(31 - i)), 1'b0, '0, '0);
    end

    for (int i = 0; i < N_WRITES; i++) begin
      drive_cycle(random_word(), 1'b1, random_nonzero_index(), random_word());
    end
    // with the write port idle a moving write_id must not bypass
    for (int i = 0; i < `NREGS; i++) begin
      drive_cycle(with_sources(random_word(), 5'(i), 5'(i + 13)), 1'b0, 5'(i), random_word());
    end

    for (int i = 0; i < N_X0_WRITES; i++) begin
      drive_cycle(with_sources(random_word(), '0, '0), 1'b1, '0, random_word() | 32'h1);
    end
    drive_cycle(with_sources(random_word(), '0, '0), 1'b0, '0, '0);

    for (int i = 0; i < N_BYPASS; i++) begin
      idx = random_nonzero_index();
      drive_cycle(with_sources(random_word(), idx, idx), 1'b1, idx, random_word());
    end
    for (int i = 0; i < N_BYPASS; i++) begin
      idx = random_nonzero_index();
      drive_cycle(with_sources(random_word(), idx, idx), 1'b0, idx, random_word());
    end

    // every opcode against every funct3 and both funct7 bit 5 values
    for (int k = 0; k < N_OPCODES; k++) begin
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int alt = 0; alt < 2; alt++) begin
          instr = random_word();
          instr[6:0]   = opcode_list[k];
          instr[14:12] = 3'(f3);
          instr[30]    = alt[0];
          drive_with_noise(instr);
        end
      end
    end
    for (int i = 0; i < N_RANDOM_WORDS; i++) begin
      drive_with_noise(random_word());  // mostly unknown opcodes
    end

    for (int k = 0; k < N_OPCODES; k++) begin
      for (int i = 0; i < N_IMM_PER_OP; i++) begin
        instr = random_word();
        instr[6:0] = opcode_list[k];
        instr[31]  = i[0];  // half of them negative
        drive_with_noise(instr);
      end
    end

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== logic/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
  input  isa_pkg::instruction_t instruction,
  output ctrl_pkg::control_t    control
);

  logic              alt_funct;  // funct7 bit 5
  logic              is_reg_op;
  ctrl_pkg::alu_op_t alu_op;

  assign alt_funct = instruction.funct7[5];
  assign is_reg_op = (instruction.opcode == isa_pkg::OP_REG);

  // funct3 picks the ALU operation and funct7 bit 5 only matters for the alternate ops
  always_comb begin
    alu_op = ctrl_pkg::ALU_ADD;  // address and link computations all add
    case (instruction.opcode)
      isa_pkg::OP_REG,
      isa_pkg::OP_IMM: begin
        case (instruction.funct3)
          3'b000: begin
            // addi has no subtract form, so funct7 is only looked at for OP_REG
            if (is_reg_op && alt_funct) begin
              alu_op = ctrl_pkg::ALU_SUB;
            end else begin
              alu_op = ctrl_pkg::ALU_ADD;
            end
          end
          3'b001: alu_op = ctrl_pkg::ALU_SHIFT_LEFT;
          3'b010: alu_op = ctrl_pkg::ALU_LESS_THAN_SIGNED;
          3'b011: alu_op = ctrl_pkg::ALU_LESS_THAN_UNSIGNED;
          3'b100: alu_op = ctrl_pkg::ALU_XOR;
          3'b101: begin
            if (alt_funct) begin
              alu_op = ctrl_pkg::ALU_SHIFT_RIGHT_AR;
            end else begin
              alu_op = ctrl_pkg::ALU_SHIFT_RIGHT;
            end
          end
          3'b110: alu_op = ctrl_pkg::ALU_OR;
          default: alu_op = ctrl_pkg::ALU_AND;  // 3'b111
        endcase
      end
      isa_pkg::OP_BRANCH: begin
        // funct3 bit 0 only inverts the condition and execute handles that
        case (instruction.funct3[2:1])
          2'b00: alu_op = ctrl_pkg::ALU_SUB;                 // beq, bne
          2'b10: alu_op = ctrl_pkg::ALU_LESS_THAN_SIGNED;    // blt, bge
          2'b11: alu_op = ctrl_pkg::ALU_LESS_THAN_UNSIGNED;  // bltu, bgeu
          default: alu_op = ctrl_pkg::ALU_ADD;
        endcase
      end
      default: begin
        alu_op = ctrl_pkg::ALU_ADD;
      end
    endcase
  end

  // format and side effect flags
  always_comb begin
    control.encoding   = isa_pkg::R_TYPE;
    control.alu_op     = alu_op;
    control.alu_src    = 1'b0;
    control.mem_read   = 1'b0;
    control.mem_write  = 1'b0;
    control.mem_to_reg = 1'b0;
    control.is_branch  = 1'b0;
    control.reg_write  = 1'b0;

    case (instruction.opcode)
      isa_pkg::OP_REG: begin
        control.reg_write = 1'b1;
      end
      isa_pkg::OP_IMM,
      isa_pkg::OP_JALR: begin
        control.encoding  = isa_pkg::I_TYPE;
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      isa_pkg::OP_LOAD: begin
        control.encoding   = isa_pkg::I_TYPE;
        control.alu_src    = 1'b1;
        control.mem_read   = 1'b1;
        control.mem_to_reg = 1'b1;
        control.reg_write  = 1'b1;
      end
      isa_pkg::OP_STORE: begin
        control.encoding  = isa_pkg::S_TYPE;
        control.alu_src   = 1'b1;
        control.mem_write = 1'b1;
      end
      isa_pkg::OP_BRANCH: begin
        control.encoding  = isa_pkg::B_TYPE;  // compares two registers
        control.is_branch = 1'b1;
      end
      isa_pkg::OP_LUI,
      isa_pkg::OP_AUIPC: begin
        control.encoding  = isa_pkg::U_TYPE;
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      isa_pkg::OP_JAL: begin
        control.encoding  = isa_pkg::J_TYPE;
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      default: begin
        // an unknown opcode leaves the word inert so it behaves like a bubble
      end
    endcase

    control.write_back_id = control.reg_write ? instruction.rd : '0;
  end

endmodule

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

  // operations the execute stage ALU understands
  typedef enum logic [3:0] {
    ALU_AND                = 4'd0,
    ALU_OR                 = 4'd1,
    ALU_XOR                = 4'd2,
    ALU_ADD                = 4'd3,
    ALU_SUB                = 4'd4,
    ALU_SHIFT_LEFT         = 4'd5,
    ALU_SHIFT_RIGHT        = 4'd6,
    ALU_SHIFT_RIGHT_AR     = 4'd7,
    ALU_LESS_THAN_UNSIGNED = 4'd8,
    ALU_LESS_THAN_SIGNED   = 4'd9
  } alu_op_t;

  // control word handed from decode to execute
  // it travels down the pipeline with the instruction, the later stages
  // peel off the fields they need
  typedef struct packed {
    isa_pkg::encoding_t encoding;
    alu_op_t            alu_op;
    logic               alu_src;        // 1 picks the immediate as operand b
    logic               mem_read;
    logic               mem_write;
    logic               mem_to_reg;     // write back load data instead of the ALU result
    logic               is_branch;
    logic               reg_write;
    isa_pkg::reg_idx_t  write_back_id;  // zero when nothing is written back
  } control_t;

endpackage

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  isa_pkg::instruction_t instruction,

  // result coming back from write back
  input  logic                  reg_write,
  input  isa_pkg::reg_idx_t     write_id,
  input  isa_pkg::word_t        write_data,

  output ctrl_pkg::control_t    control,
  output isa_pkg::word_t        immediate_data,
  output isa_pkg::reg_idx_t     rs1,
  output isa_pkg::reg_idx_t     rs2,
  output isa_pkg::word_t        read1_data,
  output isa_pkg::word_t        read2_data
);

  // source indices sit at the same bit positions in every format, so they
  // are taken straight from the instruction and sent on for hazard checks
  assign rs1 = instruction.rs1;
  assign rs2 = instruction.rs2;

  control_decoder control_decoder_inst (
    .instruction (instruction),
    .control     (control)
  );

  // the format the decoder found picks the layout without a second opcode decode
  imm_gen imm_gen_inst (
    .instruction    (instruction),
    .encoding       (control.encoding),
    .immediate_data (immediate_data)
  );

  register_file register_file_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .read1_id   (rs1),
    .read2_id   (rs2),
    .write_en   (reg_write),
    .write_id   (write_id),
    .write_data (write_data),
    .read1_data (read1_data),  // already carries the write back bypass
    .read2_data (read2_data)
  );

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module imm_gen (
  input  isa_pkg::instruction_t instruction,
  input  isa_pkg::encoding_t    encoding,
  output isa_pkg::word_t        immediate_data
);

  logic [31:0] ir;  // raw instruction bits since the formats cut across the struct fields
  logic        sign;

  assign ir   = instruction;
  assign sign = ir[31];  // every format keeps its sign in bit 31

  always_comb begin
    case (encoding)
      isa_pkg::I_TYPE: begin
        immediate_data = {{(`XLEN-12){sign}}, ir[31:20]};
      end
      isa_pkg::S_TYPE: begin
        immediate_data = {{(`XLEN-12){sign}}, ir[31:25], ir[11:7]};
      end
      isa_pkg::B_TYPE: begin
        // branch offsets are in halfwords, so bit 0 is always clear
        immediate_data = {{(`XLEN-13){sign}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      isa_pkg::U_TYPE: begin
        immediate_data = {ir[31:12], 12'b0};  // already fills the word
      end
      isa_pkg::J_TYPE: begin
        immediate_data = {{(`XLEN-21){sign}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      default: begin
        immediate_data = '0;  // R format has no immediate
      end
    endcase
  end

endmodule

// ==== logic/isa_pkg.sv ====
`include "rv_defines.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;  // operand, write data and immediate values

  typedef logic [`REG_IDX_W-1:0] reg_idx_t;  // register file index

  // major opcodes of the RV32I base set, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  // instruction formats, used to pick the immediate layout
  typedef enum logic [2:0] {
    R_TYPE = 3'd0,
    I_TYPE = 3'd1,
    S_TYPE = 3'd2,
    B_TYPE = 3'd3,
    U_TYPE = 3'd4,
    J_TYPE = 3'd5
  } encoding_t;

  // field split of the R layout
  // the other formats reuse the same bit positions for rs1, rs2 and rd,
  // their immediates are pulled out of the raw bits by imm_gen
  typedef struct packed {
    logic [6:0] funct7;  // bit 5 marks sub and arithmetic shift
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } instruction_t;

endpackage

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module register_file (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::reg_idx_t read1_id,
  input  isa_pkg::reg_idx_t read2_id,
  input  logic              write_en,
  input  isa_pkg::reg_idx_t write_id,
  input  isa_pkg::word_t    write_data,
  output isa_pkg::word_t    read1_data,
  output isa_pkg::word_t    read2_data
);

  isa_pkg::word_t regs [`NREGS];

  logic write_live;  // a real write is happening this cycle
  logic bypass1;
  logic bypass2;

  // x0 is never written, so it keeps the zero from reset
  assign write_live = write_en && (write_id != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[write_id] <= write_data;
    end
  end

  // the result arriving from write back this cycle is forwarded straight to
  // the read ports so decode never sees the stale word
  assign bypass1 = write_live && (write_id == read1_id);
  assign bypass2 = write_live && (write_id == read2_id);

  always_comb begin
    if (read1_id == '0) begin
      read1_data = '0;
    end else if (bypass1) begin
      read1_data = write_data;
    end else begin
      read1_data = regs[read1_id];
    end
  end

  always_comb begin
    if (read2_id == '0) begin
      read2_data = '0;
    end else if (bypass2) begin
      read2_data = write_data;
    end else begin
      read2_data = regs[read2_id];
    end
  end

endmodule

// ==== logic/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// widths shared by the decode stage and everything that talks to it

// data path width of the RV32I core
`define XLEN 32

// architectural register count, x0 included
`define NREGS 32

// bits needed to name one of the registers above
`define REG_IDX_W 5

`endif

// ==== run.sh ====
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
  -f all.f \
  --top-module decode_tb \
  -Mdir obj_dir

# the simulator output is kept in a variable, no log file is written
sim_output=$(./obj_dir/Vdecode_tb)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
